/* Makefile */
SIM      := verilator
TOP      := tb_ex_stage
FILELIST := filelist.f
FLAGS    := --binary --assert -j 0 --top-module $(TOP)
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)

SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(OBJ_DIR)/V%: $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST) -o V$*

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

/* filelist.f */
+incdir+include
src/hilo_pkg.sv
src/mul.sv
src/div.sv
src/alu.sv
src/hilo_reg.sv
src/ex_stage.sv
tb/tb_ex_stage.sv

/* include/alu_defs.svh */
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// word width and divider iteration count
`define DATA_W    32
`define DIV_STEPS 32

//////////////////////////////////////////////////////////////
// 5-bit alu control codes
//////////////////////////////////////////////////////////////
`define ALU_NOP_CONTROL   5'b00000 // passes src_a through
`define ALU_AND_CONTROL   5'b00001
`define ALU_OR_CONTROL    5'b00010
`define ALU_NOR_CONTROL   5'b00011
`define ALU_XOR_CONTROL   5'b00100
`define ALU_ADD_CONTROL   5'b00101 // traps on signed overflow
`define ALU_ADDU_CONTROL  5'b00110
`define ALU_SUB_CONTROL   5'b00111 // traps on signed overflow
`define ALU_SUBU_CONTROL  5'b01000
`define ALU_SLT_CONTROL   5'b01001
`define ALU_SLTU_CONTROL  5'b01010
`define ALU_SLLV_CONTROL  5'b01011 // shift by src_a[4:0]
`define ALU_SRLV_CONTROL  5'b01100
`define ALU_SRAV_CONTROL  5'b01101
`define ALU_SLL_CONTROL   5'b01110 // shift by sa
`define ALU_SRL_CONTROL   5'b01111
`define ALU_SRA_CONTROL   5'b10000
`define ALU_LUI_CONTROL   5'b10001
`define ALU_MULT_CONTROL  5'b10010
`define ALU_MULTU_CONTROL 5'b10011
`define ALU_DIV_CONTROL   5'b10100
`define ALU_DIVU_CONTROL  5'b10101
`define ALU_MTHI_CONTROL  5'b10110
`define ALU_MTLO_CONTROL  5'b10111

`endif

/* src/alu.sv */
`timescale 1ns/1ps
`default_nettype none
`include "alu_defs.svh"

module alu import hilo_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush,
    input  logic [`DATA_W-1:0] src_a,
    input  logic [`DATA_W-1:0] src_b,
    input  logic [4:0]         sa,
    input  logic [4:0]         alu_control,
    input  hilo_word_u         hilo,
    output logic [`DATA_W-1:0] alu_out,
    output logic               overflow,
    output logic               div_stall,
    output logic               hilo_wen,
    output hilo_word_u         hilo_next
);

    logic                 carry_bit;   // extra sign bit of the 33-bit add/sub
    logic                 mul_op;
    logic                 mul_signed;
    logic                 div_op;
    logic                 div_signed;
    logic                 mt_op;
    logic                 div_start;
    logic                 div_ready;
    logic [2*`DATA_W-1:0] product;
    hilo_word_u           div_result;

    //////////////////////////////////////////////////////////////
    // single-cycle ops
    //////////////////////////////////////////////////////////////
    always_comb begin
        carry_bit = 1'b0;
        case (alu_control)
            `ALU_NOP_CONTROL:  alu_out = src_a;
            `ALU_AND_CONTROL:  alu_out = src_a & src_b;
            `ALU_OR_CONTROL:   alu_out = src_a | src_b;
            `ALU_NOR_CONTROL:  alu_out = ~(src_a | src_b);
            `ALU_XOR_CONTROL:  alu_out = src_a ^ src_b;

            `ALU_ADD_CONTROL:  {carry_bit, alu_out} = {src_a[`DATA_W-1], src_a}
                                                    + {src_b[`DATA_W-1], src_b};
            `ALU_ADDU_CONTROL: alu_out = src_a + src_b;
            `ALU_SUB_CONTROL:  {carry_bit, alu_out} = {src_a[`DATA_W-1], src_a}
                                                    - {src_b[`DATA_W-1], src_b};
            `ALU_SUBU_CONTROL: alu_out = src_a - src_b;

            `ALU_SLT_CONTROL:  alu_out = {{(`DATA_W-1){1'b0}}, $signed(src_a) < $signed(src_b)};
            `ALU_SLTU_CONTROL: alu_out = {{(`DATA_W-1){1'b0}}, src_a < src_b};

            // variable shifts take the amount from src_a
            `ALU_SLLV_CONTROL: alu_out = src_b << src_a[4:0];
            `ALU_SRLV_CONTROL: alu_out = src_b >> src_a[4:0];
            `ALU_SRAV_CONTROL: alu_out = $signed(src_b) >>> src_a[4:0];

            `ALU_SLL_CONTROL:  alu_out = src_b << sa;
            `ALU_SRL_CONTROL:  alu_out = src_b >> sa;
            `ALU_SRA_CONTROL:  alu_out = $signed(src_b) >>> sa;

            `ALU_LUI_CONTROL:  alu_out = {src_b[15:0], 16'b0};
            default:           alu_out = '0;  // hi/lo ops
        endcase
    end

    // sign extension bit disagrees with the result sign
    assign overflow = ((alu_control == `ALU_ADD_CONTROL) || (alu_control == `ALU_SUB_CONTROL))
                    & (carry_bit ^ alu_out[`DATA_W-1]);

    //////////////////////////////////////////////////////////////
    // multiply / divide / move-to
    //////////////////////////////////////////////////////////////
    assign mul_signed = (alu_control == `ALU_MULT_CONTROL);
    assign mul_op     = mul_signed | (alu_control == `ALU_MULTU_CONTROL);
    assign div_signed = (alu_control == `ALU_DIV_CONTROL);
    assign div_op     = div_signed | (alu_control == `ALU_DIVU_CONTROL);
    assign mt_op      = (alu_control == `ALU_MTHI_CONTROL) | (alu_control == `ALU_MTLO_CONTROL);

    assign div_start  = div_op & ~div_ready;
    assign div_stall  = div_start & ~flush;  // flush drops the stall at once

    mul u_mul (
        .src_a      (src_a),
        .src_b      (src_b),
        .signed_mul (mul_signed),
        .product    (product)
    );

    div u_div (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .start      (div_start),
        .signed_div (div_signed),
        .dividend   (src_a),
        .divisor    (src_b),
        .ready      (div_ready),
        .result     (div_result)
    );

    always_comb begin
        hilo_next = hilo;                     // move-to keeps the other half
        if (mul_op) begin
            hilo_next.prod = product;
        end else if (div_op) begin
            hilo_next = div_result;
        end else if (alu_control == `ALU_MTHI_CONTROL) begin
            hilo_next.half.hi = src_a;
        end else if (alu_control == `ALU_MTLO_CONTROL) begin
            hilo_next.half.lo = src_a;
        end
    end

    assign hilo_wen = mul_op | mt_op | (div_ready & ~flush);

endmodule

`default_nettype wire

/* src/div.sv */
`timescale 1ns/1ps
`default_nettype none
`include "alu_defs.svh"

module div import hilo_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush,
    input  logic               start,
    input  logic               signed_div,
    input  logic [`DATA_W-1:0] dividend,
    input  logic [`DATA_W-1:0] divisor,
    output logic               ready,
    output hilo_word_u         result
);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_BUSY = 2'd1;
    localparam logic [1:0] S_DONE = 2'd2;
    localparam int         CNT_W  = $clog2(`DIV_STEPS + 1);

    logic [1:0]           state;
    logic [CNT_W-1:0]     cnt;

    logic [2*`DATA_W:0]   work;      // {partial remainder, dividend / quotient bits}
    logic [`DATA_W-1:0]   dsr;       // divisor magnitude
    logic                 neg_quot;
    logic                 neg_rem;

    logic [`DATA_W-1:0]   abs_dvd;
    logic [`DATA_W-1:0]   abs_dsr;
    logic [2*`DATA_W:0]   shifted;
    logic [`DATA_W:0]     diff;
    logic [`DATA_W-1:0]   rem_mag;
    logic [`DATA_W-1:0]   quot_mag;

    //////////////////////////////////////////////////////////////
    // operand conditioning and one restoring step
    //////////////////////////////////////////////////////////////
    always_comb begin
        abs_dvd = (signed_div && dividend[`DATA_W-1]) ? -dividend : dividend;
        abs_dsr = (signed_div && divisor[`DATA_W-1]) ? -divisor : divisor;

        shifted = {work[2*`DATA_W-1:0], 1'b0};
        diff    = shifted[2*`DATA_W:`DATA_W] - {1'b0, dsr}; // top bit set means borrow
    end

    //////////////////////////////////////////////////////////////
    // control fsm
    //////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_IDLE;
            cnt   <= '0;
        end else if (flush) begin
            state <= S_IDLE;            // abandon without a ready pulse
            cnt   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state <= S_BUSY;
                        cnt   <= '0;
                    end
                end
                S_BUSY: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(`DIV_STEPS - 1)) begin
                        state <= S_DONE;
                    end
                end
                S_DONE:  state <= S_IDLE;  // result taken this cycle
                default: state <= S_IDLE;
            endcase
        end
    end

    // datapath follows the fsm state
    always_ff @(posedge clk) begin
        if (state == S_IDLE && start) begin
            work     <= {{(`DATA_W+1){1'b0}}, abs_dvd};
            dsr      <= abs_dsr;
            neg_quot <= signed_div & (dividend[`DATA_W-1] ^ divisor[`DATA_W-1]);
            neg_rem  <= signed_div & dividend[`DATA_W-1]; // follows the dividend
        end else if (state == S_BUSY) begin
            if (diff[`DATA_W]) begin
                work <= shifted;                                   // restore
            end else begin
                work <= {diff, shifted[`DATA_W-1:1], 1'b1};
            end
        end
    end

    //////////////////////////////////////////////////////////////
    // signed fix-up and result
    //////////////////////////////////////////////////////////////
    assign rem_mag  = work[2*`DATA_W-1:`DATA_W];
    assign quot_mag = work[`DATA_W-1:0];
    assign ready    = (state == S_DONE);

    always_comb begin
        result.half.hi = neg_rem  ? -rem_mag  : rem_mag;
        result.half.lo = neg_quot ? -quot_mag : quot_mag;
    end

endmodule

`default_nettype wire

/* src/ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "alu_defs.svh"

module ex_stage import hilo_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush,
    input  logic [`DATA_W-1:0] src_a,
    input  logic [`DATA_W-1:0] src_b,
    input  logic [4:0]         sa,
    input  logic [4:0]         alu_control,
    output logic [`DATA_W-1:0] alu_out,
    output logic               overflow,
    output logic               div_stall,
    output hilo_word_u         hilo
);

    logic       hilo_wen;
    hilo_word_u hilo_next;

    //////////////////////////////////////////////////////////////
    // arithmetic unit
    //////////////////////////////////////////////////////////////
    alu u_alu (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .src_a       (src_a),
        .src_b       (src_b),
        .sa          (sa),
        .alu_control (alu_control),
        .hilo        (hilo),       // current value for move-to merge
        .alu_out     (alu_out),
        .overflow    (overflow),
        .div_stall   (div_stall),
        .hilo_wen    (hilo_wen),
        .hilo_next   (hilo_next)
    );

    // hi/lo register
    hilo_reg u_hilo_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .wen   (hilo_wen),
        .d     (hilo_next),
        .q     (hilo)
    );

endmodule

`default_nettype wire

/* src/hilo_pkg.sv */
`default_nettype none
`include "alu_defs.svh"

package hilo_pkg;

    // one 64-bit word, read either as a full product or as two halves
    typedef union packed {
        logic [2*`DATA_W-1:0] prod;   // mult / multu
        struct packed {
            logic [`DATA_W-1:0] hi;   // remainder after a divide
            logic [`DATA_W-1:0] lo;   // quotient after a divide
        } half;
    } hilo_word_u;

endpackage

`default_nettype wire

/* src/hilo_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module hilo_reg import hilo_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wen,
    input  hilo_word_u d,
    output hilo_word_u q
);

    //////////////////////////////////////////////////////////////
    // architectural hi/lo state
    //////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q <= '0;
        end else if (wen) begin
            q <= d;            // mult, div or move-to
        end
    end

endmodule

`default_nettype wire

/* src/mul.sv */
`timescale 1ns/1ps
`default_nettype none
`include "alu_defs.svh"

module mul (
    input  logic [`DATA_W-1:0]   src_a,
    input  logic [`DATA_W-1:0]   src_b,
    input  logic                 signed_mul,
    output logic [2*`DATA_W-1:0] product
);

    logic [2*`DATA_W-1:0] ext_a;
    logic [2*`DATA_W-1:0] ext_b;

    // sign bits only replicate for mult
    assign ext_a = {{`DATA_W{signed_mul & src_a[`DATA_W-1]}}, src_a};
    assign ext_b = {{`DATA_W{signed_mul & src_b[`DATA_W-1]}}, src_b};

    // low 64 bits of the extended product are exact for both forms
    assign product = ext_a * ext_b;

endmodule

`default_nettype wire

/* tb/tb_ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "alu_defs.svh"

module tb_ex_stage import hilo_pkg::*; ();

    localparam int N_RAND      = 8;
    localparam int NUM_TESTS   = 24 * N_RAND + 60;
    localparam int WATCHDOG_NS = NUM_TESTS * 40 * 40 + 20000; // 40 cycles of 40 ns each
    localparam logic [4:0] LOGIC_OPS [12] = '{`ALU_NOP_CONTROL, `ALU_AND_CONTROL,
        `ALU_OR_CONTROL, `ALU_NOR_CONTROL, `ALU_XOR_CONTROL, `ALU_SLLV_CONTROL,
        `ALU_SRLV_CONTROL, `ALU_SRAV_CONTROL, `ALU_SLL_CONTROL, `ALU_SRL_CONTROL,
        `ALU_SRA_CONTROL, `ALU_LUI_CONTROL};
    localparam logic [4:0] ARITH_OPS [6] = '{`ALU_ADD_CONTROL, `ALU_ADDU_CONTROL,
        `ALU_SUB_CONTROL, `ALU_SUBU_CONTROL, `ALU_SLT_CONTROL, `ALU_SLTU_CONTROL};

    logic        clk = 1'b0;
    logic        rst_n;
    logic        flush;
    logic [31:0] src_a;
    logic [31:0] src_b;
    logic [4:0]  sa;
    logic [4:0]  alu_control;
    logic [31:0] alu_out;
    logic        overflow;
    logic        div_stall;
    hilo_word_u  hilo;

    integer      seed = 32'hb617_2448;
    string       test_name;
    logic [31:0] exp_out;
    logic        exp_ovf;
    logic [63:0] exp_hilo;
    logic [63:0] model_hilo;   // hi/lo as the reference sees it
    logic        chk_comb;     // alu_out, overflow, stall low
    logic        chk_len;      // divide stall length
    int          meas_len;
    int          req_id;
    int          done_id;
    int          n_checks;
    int          n_fail;
    int          grp_checks;
    int          grp_fail;

    ex_stage dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .src_a       (src_a),
        .src_b       (src_b),
        .sa          (sa),
        .alu_control (alu_control),
        .alu_out     (alu_out),
        .overflow    (overflow),
        .div_stall   (div_stall),
        .hilo        (hilo)
    );

    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////
    function automatic void exp_result(
        input  logic [4:0]  op,
        input  logic [31:0] a,
        input  logic [31:0] b,
        input  logic [4:0]  s,
        input  logic [63:0] old_hilo,
        output logic [31:0] r,
        output logic        ovf,
        output logic [63:0] nh
    );
        longint             wide;
        logic [63:0]        sh;
        logic [4:0]         amt;
        logic signed [31:0] q;
        logic signed [31:0] rm;
        r   = 32'd0;
        ovf = 1'b0;
        nh  = old_hilo;
        amt = (op == `ALU_SLL_CONTROL || op == `ALU_SRL_CONTROL || op == `ALU_SRA_CONTROL)
            ? s : a[4:0];
        case (op)
            `ALU_NOP_CONTROL: r = a;
            `ALU_AND_CONTROL: r = a & b;
            `ALU_OR_CONTROL:  r = a | b;
            `ALU_NOR_CONTROL: r = ~(a | b);
            `ALU_XOR_CONTROL: r = a ^ b;
            `ALU_ADD_CONTROL, `ALU_ADDU_CONTROL, `ALU_SUB_CONTROL, `ALU_SUBU_CONTROL: begin
                if (op == `ALU_ADD_CONTROL || op == `ALU_ADDU_CONTROL) begin
                    wide = longint'($signed(a)) + longint'($signed(b));
                end else begin
                    wide = longint'($signed(a)) - longint'($signed(b));
                end
                r   = wide[31:0];
                // only the trapping forms flag a result outside the signed range
                ovf = (op == `ALU_ADD_CONTROL || op == `ALU_SUB_CONTROL)
                    && (wide > longint'(32'sh7fff_ffff) || wide < longint'(32'sh8000_0000));
            end
            `ALU_SLT_CONTROL:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            `ALU_SLTU_CONTROL: r = (a < b) ? 32'd1 : 32'd0;
            `ALU_SLLV_CONTROL, `ALU_SLL_CONTROL: r = b << amt;
            `ALU_SRLV_CONTROL, `ALU_SRL_CONTROL: r = b >> amt;
            `ALU_SRAV_CONTROL, `ALU_SRA_CONTROL: begin
                sh = {{32{b[31]}}, b} >> amt;   // sign fill from the upper word
                r  = sh[31:0];
            end
            `ALU_LUI_CONTROL:   r  = {b[15:0], 16'h0000};
            `ALU_MULT_CONTROL:  nh = longint'($signed(a)) * longint'($signed(b));
            `ALU_MULTU_CONTROL: nh = {32'd0, a} * {32'd0, b};
            `ALU_DIV_CONTROL: begin
                q  = $signed(a) / $signed(b);   // truncates toward zero
                rm = $signed(a) % $signed(b);   // sign of the dividend
                nh = {rm, q};
            end
            `ALU_DIVU_CONTROL: nh = {a % b, a / b};
            `ALU_MTHI_CONTROL: nh = {a, old_hilo[31:0]};
            `ALU_MTLO_CONTROL: nh = {old_hilo[63:32], a};
            default: ;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // checks 5 ns after each rising edge
    ////////////////////////////////////////////////////////////
    task automatic check_val(input string what, input logic [63:0] exp,
                             input logic [63:0] act);
        n_checks++;
        assert (act === exp) else begin
            $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
            n_fail++;
        end
    endtask

    always @(posedge clk) begin
        #5;
        if (req_id != done_id) begin
            done_id = req_id;
            check_val("hilo", exp_hilo, hilo.prod);
            if (chk_comb) begin
                check_val("alu_out", {32'd0, exp_out}, {32'd0, alu_out});
                check_val("overflow", {63'd0, exp_ovf}, {63'd0, overflow});
                check_val("div_stall", 64'd0, {63'd0, div_stall});
            end
            if (chk_len) begin
                check_val("stall cycles", 64'(`DIV_STEPS + 1), 64'(meas_len));
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus driven on the falling edge
    ////////////////////////////////////////////////////////////
    task automatic run_op(input string name, input logic [4:0] op, input logic [31:0] a,
                          input logic [31:0] b, input logic [4:0] s);
        @(negedge clk);
        flush       = 1'b0;
        alu_control = op;
        src_a       = a;
        src_b       = b;
        sa          = s;
        exp_result(op, a, b, s, model_hilo, exp_out, exp_ovf, exp_hilo);
        model_hilo  = exp_hilo;
        test_name   = $sformatf("%s op %0d", name, op);
        chk_comb    = 1'b1;
        chk_len     = 1'b0;
        req_id++;
    endtask

    task automatic run_rand(input string name, input logic [4:0] op);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] s;
        a = $random(seed);
        b = $random(seed);
        s = $random(seed);
        run_op(name, op, a, b, s[4:0]);
    endtask

    // op held until the stall drops, then hi/lo checked after the write edge
    task automatic run_div(input logic [4:0] op, input logic [31:0] a, input logic [31:0] b);
        int cycles;
        cycles = 0;
        @(negedge clk);
        flush       = 1'b0;
        alu_control = op;
        src_a       = a;
        src_b       = b;
        #1;
        while (div_stall && cycles < 2 * `DIV_STEPS) begin
            cycles++;
            @(negedge clk);
            #1;
        end
        exp_result(op, a, b, 5'd0, model_hilo, exp_out, exp_ovf, exp_hilo);
        model_hilo = exp_hilo;
        meas_len   = cycles;
        test_name  = $sformatf("div op %0d %h/%h", op, a, b);
        chk_comb   = 1'b0;
        chk_len    = 1'b1;
        req_id++;
    endtask

    task automatic run_div_rand(input logic [4:0] op);
        logic [31:0] a;
        logic [31:0] b;
        a = $random(seed);
        b = $random(seed);
        if (a[0]) begin
            b = b >> b[4:0];   // smaller divisors now and then
        end
        if (b == 32'd0) begin
            b = 32'd1;
        end
        run_div(op, a, b);
    endtask

    task automatic run_flush();
        logic [63:0] held;
        held = model_hilo;
        @(negedge clk);
        flush       = 1'b0;
        alu_control = `ALU_DIV_CONTROL;
        src_a       = 32'd1000;
        src_b       = 32'd7;
        repeat (10) @(negedge clk);
        test_name = "flush stall";
        check_val("div_stall before flush", 64'd1, {63'd0, div_stall});
        flush     = 1'b1;
        exp_out   = 32'd0;
        exp_ovf   = 1'b0;
        exp_hilo  = held;
        chk_comb  = 1'b1;
        chk_len   = 1'b0;
        req_id++;
        repeat (40) run_op("flush hold", `ALU_NOP_CONTROL, 32'd0, 32'd0, 5'd0);
    endtask

    task automatic finish_group(input string name);
        @(negedge clk);
        flush       = 1'b0;
        alu_control = `ALU_NOP_CONTROL;
        $display("test %s done: %0d checks, %0d failed", name, n_checks - grp_checks,
                 n_fail - grp_fail);
        grp_checks  = n_checks;
        grp_fail    = n_fail;
    endtask

    initial begin
        rst_n       = 1'b0;
        flush       = 1'b0;
        src_a       = 32'd0;
        src_b       = 32'd0;
        sa          = 5'd0;
        alu_control = `ALU_NOP_CONTROL;
        model_hilo  = 64'd0;
        exp_out     = 32'd0;
        exp_ovf     = 1'b0;
        exp_hilo    = 64'd0;
        chk_comb    = 1'b0;
        chk_len     = 1'b0;
        meas_len    = 0;
        test_name   = "reset";
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < N_RAND; i++) begin
            for (int k = 0; k < 12; k++) run_rand("logic", LOGIC_OPS[k]);
        end
        finish_group("logic_shift");

        for (int i = 0; i < N_RAND; i++) begin
            for (int k = 0; k < 6; k++) run_rand("arith", ARITH_OPS[k]);
        end
        run_op("add max+1", `ALU_ADD_CONTROL, 32'h7fff_ffff, 32'd1, 5'd0);
        run_op("addu max+1", `ALU_ADDU_CONTROL, 32'h7fff_ffff, 32'd1, 5'd0);
        run_op("sub min-1", `ALU_SUB_CONTROL, 32'h8000_0000, 32'd1, 5'd0);
        run_op("subu min-1", `ALU_SUBU_CONTROL, 32'h8000_0000, 32'd1, 5'd0);
        run_op("sub equal", `ALU_SUB_CONTROL, 32'hdead_beef, 32'hdead_beef, 5'd0);
        run_op("slt equal", `ALU_SLT_CONTROL, 32'hdead_beef, 32'hdead_beef, 5'd0);
        run_op("sltu equal", `ALU_SLTU_CONTROL, 32'hdead_beef, 32'hdead_beef, 5'd0);
        finish_group("arith");

        for (int i = 0; i < N_RAND; i++) begin
            run_rand("mult", `ALU_MULT_CONTROL);
            run_rand("multu", `ALU_MULTU_CONTROL);
        end
        run_op("mult neg", `ALU_MULT_CONTROL, 32'hffff_fffd, 32'd5, 5'd0);
        run_op("multu neg", `ALU_MULTU_CONTROL, 32'hffff_fffd, 32'd5, 5'd0);
        finish_group("multiply");

        for (int i = 0; i < N_RAND; i++) begin
            run_div_rand(`ALU_DIV_CONTROL);
            run_div_rand(`ALU_DIVU_CONTROL);
        end
        run_div(`ALU_DIV_CONTROL, 32'hffff_fff9, 32'd2);          // -7 / 2
        run_div(`ALU_DIV_CONTROL, 32'd7, 32'hffff_fffe);          // 7 / -2
        run_div(`ALU_DIV_CONTROL, 32'hffff_fff9, 32'hffff_fffe);
        finish_group("divide");

        for (int i = 0; i < N_RAND; i++) begin
            run_rand("mthi", `ALU_MTHI_CONTROL);
            run_rand("mtlo", `ALU_MTLO_CONTROL);
        end
        finish_group("move_to");

        run_flush();
        finish_group("flush");

        $display("%0d checks, %0d passed, %0d failed", n_checks, n_checks - n_fail, n_fail);
        if (n_fail == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
